//--- hw/fetch_pkg.sv
// Fetch-side definitions: address and instruction widths, TLB size and exception causes
`default_nettype none

package fetch_pkg;

    // Virtual address width
    localparam int ADDR_SIZE = 40;

    // One instruction per fetch
    localparam int INST_SIZE = 32;

    // Page number taken from address bits 39 to 12
    localparam int VPN_SIZE = 28;

    // Number of entries in the instruction TLB
    localparam int TLB_SLOTS = 4;

    // Cause reported with every delivered fetch
    typedef enum logic [1:0] {
        CauseNone       = 2'd0,
        CauseMisaligned = 2'd1,
        CauseFetchFault = 2'd2
    } fetch_cause_e;

endpackage

`default_nettype wire

//--- hw/icache_pkg.sv
// Instruction cache definitions: line geometry, index split, response delay and FSM states
`default_nettype none

package icache_pkg;

    // A line holds four instructions
    localparam int LINE_SIZE = 128;

    // Byte offset bits inside a line
    localparam int LINE_OFFSET = 4;

    // Page-offset index sent with each request
    localparam int IDX_SIZE = 12;

    // Line select is index bits 11 to 4
    localparam int SET_BITS = 8;

    // Cycles from request pulse to response pulse
    localparam int RESP_LATENCY = 2;

    // Request state of the cache interface
    typedef enum logic [1:0] {
        NoReq     = 2'd0,
        ReqValid  = 2'd1,
        RespReady = 2'd2
    } icache_state_e;

endpackage

`default_nettype wire

//--- hw/pc_gen.sv
// PC generator that loads on redirect, steps by one instruction and halts on an exception
`timescale 1ns/1ps
`default_nettype none

module pc_gen (
    input  wire logic                            clk_i,
    input  wire logic                            rstn_i,
    input  wire logic                            redirect_valid_i,
    input  wire logic [fetch_pkg::ADDR_SIZE-1:0] redirect_pc_i,
    input  wire logic                            fetch_valid_i,
    input  var  fetch_pkg::fetch_cause_e         fetch_cause_i,
    output logic                                 fetch_req_valid_o,
    output logic [fetch_pkg::ADDR_SIZE-1:0]      fetch_pc_o
);

    logic [fetch_pkg::ADDR_SIZE-1:0] pc_q;
    logic                            running_q;
    logic                            pending_q;
    logic                            deliver_ok;
    logic                            deliver_xcpt;

    // Split the delivery strobe by its cause
    assign deliver_ok   = fetch_valid_i && (fetch_cause_i == fetch_pkg::CauseNone);
    assign deliver_xcpt = fetch_valid_i && (fetch_cause_i != fetch_pkg::CauseNone);

    // One pulse per address, then wait for the delivery
    assign fetch_req_valid_o = running_q && !pending_q;
    assign fetch_pc_o        = pc_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q      <= '0;
            running_q <= 1'b0;
            pending_q <= 1'b0;
        end else if (redirect_valid_i) begin
            // Redirect wins over any delivery in the same cycle
            pc_q      <= redirect_pc_i;
            running_q <= 1'b1;
            pending_q <= 1'b0;
        end else begin
            if (deliver_ok) begin
                pc_q <= pc_q + (fetch_pkg::ADDR_SIZE)'(4);
            end
            // Stop fetching until the next redirect
            if (deliver_xcpt) begin
                running_q <= 1'b0;
            end
            // A hit answers in the request cycle, so delivery clears first
            if (fetch_valid_i) begin
                pending_q <= 1'b0;
            end else if (fetch_req_valid_o) begin
                pending_q <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/itlb.sv
// Instruction TLB with four loadable page slots and a combinational fault check
`timescale 1ns/1ps
`default_nettype none

module itlb (
    input  wire logic                                     clk_i,
    input  wire logic                                     rstn_i,
    input  wire logic                                     load_valid_i,
    input  wire logic [$clog2(fetch_pkg::TLB_SLOTS)-1:0]  load_slot_i,
    input  wire logic [fetch_pkg::VPN_SIZE-1:0]           load_vpn_i,
    input  wire logic                                     req_valid_i,
    input  wire logic [fetch_pkg::VPN_SIZE-1:0]           req_vpn_i,
    output logic                                          xcpt_o
);

    logic [fetch_pkg::VPN_SIZE-1:0]  slot_vpn_q [fetch_pkg::TLB_SLOTS];
    logic [fetch_pkg::TLB_SLOTS-1:0] slot_valid_q;
    logic [fetch_pkg::TLB_SLOTS-1:0] slot_hit;

    // Slot table, written one entry per load strobe
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            slot_valid_q <= '0;
            for (int i = 0; i < fetch_pkg::TLB_SLOTS; i++) begin
                slot_vpn_q[i] <= '0;
            end
        end else if (load_valid_i) begin
            slot_valid_q[load_slot_i] <= 1'b1;
            slot_vpn_q[load_slot_i]   <= load_vpn_i;
        end
    end

    // Compare the fetch page against every valid slot
    always_comb begin
        for (int i = 0; i < fetch_pkg::TLB_SLOTS; i++) begin
            slot_hit[i] = slot_valid_q[i] && (slot_vpn_q[i] == req_vpn_i);
        end
    end

    // Unmapped page on a live request is a fetch fault
    assign xcpt_o = req_valid_i && !(|slot_hit);

endmodule

`default_nettype wire

//--- hw/icache_array.sv
// Instruction cache line store with a fill port and a fixed-latency read response
`timescale 1ns/1ps
`default_nettype none

module icache_array (
    input  wire logic                              clk_i,
    input  wire logic                              rstn_i,
    input  wire logic                              fill_valid_i,
    input  wire logic [icache_pkg::SET_BITS-1:0]   fill_set_i,
    input  wire logic [icache_pkg::LINE_SIZE-1:0]  fill_line_i,
    input  wire logic                              req_valid_i,
    input  wire logic [icache_pkg::IDX_SIZE-1:0]   req_idx_i,
    output logic                                   resp_valid_o,
    output logic [icache_pkg::LINE_SIZE-1:0]       resp_line_o
);

    logic [icache_pkg::LINE_SIZE-1:0]    lines [1 << icache_pkg::SET_BITS];
    logic [icache_pkg::SET_BITS-1:0]     req_set;
    logic [icache_pkg::RESP_LATENCY-1:0] valid_pipe_q;
    logic [icache_pkg::LINE_SIZE-1:0]    line_pipe_q [icache_pkg::RESP_LATENCY];

    // Set bits sit just above the line offset
    assign req_set = req_idx_i[icache_pkg::IDX_SIZE-1 -: icache_pkg::SET_BITS];

    // Line storage and read data pipeline
    always_ff @(posedge clk_i) begin
        if (fill_valid_i) begin
            lines[fill_set_i] <= fill_line_i;
        end
        // Line is read in the request cycle
        if (req_valid_i) begin
            line_pipe_q[0] <= lines[req_set];
        end
        for (int i = 1; i < icache_pkg::RESP_LATENCY; i++) begin
            line_pipe_q[i] <= line_pipe_q[i-1];
        end
    end

    // Valid bits travel alongside the data
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_pipe_q <= '0;
        end else begin
            valid_pipe_q[0] <= req_valid_i;
            for (int i = 1; i < icache_pkg::RESP_LATENCY; i++) begin
                valid_pipe_q[i] <= valid_pipe_q[i-1];
            end
        end
    end

    // Response leaves the last stage
    assign resp_valid_o = valid_pipe_q[icache_pkg::RESP_LATENCY-1];
    assign resp_line_o  = line_pipe_q[icache_pkg::RESP_LATENCY-1];

endmodule

`default_nettype wire

//--- hw/icache_interface.sv
// Fetch-to-cache interface with a one-line buffer, TLB check and exception selection
`timescale 1ns/1ps
`default_nettype none

module icache_interface (
    input  wire logic                              clk_i,
    input  wire logic                              rstn_i,
    input  wire logic                              req_valid_i,
    input  wire logic [fetch_pkg::ADDR_SIZE-1:0]   req_vaddr_i,
    input  wire logic                              redirect_i,
    input  wire logic                              icache_resp_valid_i,
    input  wire logic [icache_pkg::LINE_SIZE-1:0]  icache_resp_line_i,
    input  wire logic                              tlb_xcpt_i,
    output logic                                   icache_req_valid_o,
    output logic [icache_pkg::IDX_SIZE-1:0]        icache_req_idx_o,
    output logic                                   tlb_req_valid_o,
    output logic [fetch_pkg::VPN_SIZE-1:0]         tlb_vpn_o,
    output logic                                   fetch_valid_o,
    output logic [fetch_pkg::ADDR_SIZE-1:0]        fetch_pc_o,
    output logic [fetch_pkg::INST_SIZE-1:0]        fetch_instr_o,
    output fetch_pkg::fetch_cause_e                fetch_cause_o
);

    icache_pkg::icache_state_e state_q;
    icache_pkg::icache_state_e state_d;

    logic [icache_pkg::LINE_SIZE-1:0]                          buf_line_q;
    logic [fetch_pkg::ADDR_SIZE-1:icache_pkg::LINE_OFFSET]     buf_tag_q;
    logic                                                      buf_valid_q;
    logic                                                      drop_q;
    logic                                                      hold_q;
    logic                                                      req_seen;
    logic                                                      idle;
    logic                                                      misaligned;
    logic                                                      buf_hit;
    logic                                                      resp_take;
    logic [icache_pkg::LINE_SIZE-1:0]                          line_sel;
    logic [icache_pkg::LINE_OFFSET-3:0]                        word_sel;

    // Pulse from pc_gen, or one parked while a dropped miss drains
    assign req_seen = (req_valid_i || hold_q) && !redirect_i;

    // NoReq and RespReady both accept a new fetch
    assign idle       = (state_q == icache_pkg::NoReq) || (state_q == icache_pkg::RespReady);
    assign misaligned = |req_vaddr_i[1:0];
    assign buf_hit    = buf_valid_q &&
                        (buf_tag_q == req_vaddr_i[fetch_pkg::ADDR_SIZE-1:icache_pkg::LINE_OFFSET]);

    // Response that belongs to the current fetch
    assign resp_take = (state_q == icache_pkg::ReqValid) && icache_resp_valid_i && !drop_q;

    // Page and index come straight from the fetch address
    assign tlb_vpn_o        = req_vaddr_i[fetch_pkg::ADDR_SIZE-1:icache_pkg::IDX_SIZE];
    assign icache_req_idx_o = req_vaddr_i[icache_pkg::IDX_SIZE-1:0];
    // No TLB lookup for an address already known to be misaligned
    assign tlb_req_valid_o  = idle && req_seen && !misaligned;

    always_comb begin
        state_d            = state_q;
        icache_req_valid_o = 1'b0;
        fetch_valid_o      = 1'b0;
        fetch_cause_o      = fetch_pkg::CauseNone;
        case (state_q)
            icache_pkg::NoReq, icache_pkg::RespReady: begin
                state_d = icache_pkg::NoReq;
                if (req_seen) begin
                    // Misaligned first, then fault, then buffer lookup
                    if (misaligned) begin
                        fetch_valid_o = 1'b1;
                        fetch_cause_o = fetch_pkg::CauseMisaligned;
                    end else if (tlb_xcpt_i) begin
                        fetch_valid_o = 1'b1;
                        fetch_cause_o = fetch_pkg::CauseFetchFault;
                    end else if (buf_hit) begin
                        fetch_valid_o = 1'b1;
                    end else begin
                        icache_req_valid_o = 1'b1;
                        state_d            = icache_pkg::ReqValid;
                    end
                end
            end
            icache_pkg::ReqValid: begin
                if (icache_resp_valid_i) begin
                    // Stale line goes nowhere and the parked request retries
                    fetch_valid_o = !drop_q && !redirect_i;
                    state_d = fetch_valid_o ? icache_pkg::RespReady : icache_pkg::NoReq;
                end
            end
            default: begin
                state_d = icache_pkg::NoReq;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q     <= icache_pkg::NoReq;
            buf_valid_q <= 1'b0;
            drop_q      <= 1'b0;
            hold_q      <= 1'b0;
        end else begin
            state_q <= state_d;
            if (resp_take) begin
                buf_valid_q <= 1'b1;
            end
            // Note a redirect until the outstanding response shows up
            drop_q <= (state_q == icache_pkg::ReqValid) && !icache_resp_valid_i &&
                      (drop_q || redirect_i);
            // Park a request that arrives while still waiting
            hold_q <= (state_q == icache_pkg::ReqValid) && req_seen;
        end
    end

    // Line buffer payload
    always_ff @(posedge clk_i) begin
        if (resp_take) begin
            buf_line_q <= icache_resp_line_i;
            buf_tag_q  <= req_vaddr_i[fetch_pkg::ADDR_SIZE-1:icache_pkg::LINE_OFFSET];
        end
    end

    // Word from the arriving line or from the buffer
    assign line_sel      = resp_take ? icache_resp_line_i : buf_line_q;
    assign word_sel      = req_vaddr_i[icache_pkg::LINE_OFFSET-1:2];
    assign fetch_instr_o = line_sel[word_sel * fetch_pkg::INST_SIZE +: fetch_pkg::INST_SIZE];
    assign fetch_pc_o    = req_vaddr_i;

endmodule

`default_nettype wire

//--- hw/fetch_top.sv
// Fetch front end joining the PC generator, TLB, cache interface and cache array
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  wire logic                                     clk_i,
    input  wire logic                                     rstn_i,
    input  wire logic                                     redirect_valid_i,
    input  wire logic [fetch_pkg::ADDR_SIZE-1:0]          redirect_pc_i,
    input  wire logic                                     fill_valid_i,
    input  wire logic [icache_pkg::SET_BITS-1:0]          fill_set_i,
    input  wire logic [icache_pkg::LINE_SIZE-1:0]         fill_line_i,
    input  wire logic                                     tlb_load_valid_i,
    input  wire logic [$clog2(fetch_pkg::TLB_SLOTS)-1:0]  tlb_load_slot_i,
    input  wire logic [fetch_pkg::VPN_SIZE-1:0]           tlb_load_vpn_i,
    output logic                                          fetch_valid_o,
    output logic [fetch_pkg::ADDR_SIZE-1:0]               fetch_pc_o,
    output logic [fetch_pkg::INST_SIZE-1:0]               fetch_instr_o,
    output fetch_pkg::fetch_cause_e                       fetch_cause_o
);

    logic                             fetch_req_valid;
    logic [fetch_pkg::ADDR_SIZE-1:0]  fetch_pc;
    logic                             tlb_req_valid;
    logic [fetch_pkg::VPN_SIZE-1:0]   tlb_vpn;
    logic                             tlb_xcpt;
    logic                             icache_req_valid;
    logic [icache_pkg::IDX_SIZE-1:0]  icache_idx;
    logic                             icache_resp_valid;
    logic [icache_pkg::LINE_SIZE-1:0] icache_resp_line;
    logic                             fetch_valid;
    fetch_pkg::fetch_cause_e          fetch_cause;

    // Delivery goes to decode and back to the PC generator
    assign fetch_valid_o = fetch_valid;
    assign fetch_cause_o = fetch_cause;

    pc_gen pc_gen_inst (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .redirect_valid_i  (redirect_valid_i),
        .redirect_pc_i     (redirect_pc_i),
        .fetch_valid_i     (fetch_valid),
        .fetch_cause_i     (fetch_cause),
        .fetch_req_valid_o (fetch_req_valid),
        .fetch_pc_o        (fetch_pc)
    );

    itlb itlb_inst (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .load_valid_i (tlb_load_valid_i),
        .load_slot_i  (tlb_load_slot_i),
        .load_vpn_i   (tlb_load_vpn_i),
        .req_valid_i  (tlb_req_valid),
        .req_vpn_i    (tlb_vpn),
        .xcpt_o       (tlb_xcpt)
    );

    icache_interface icache_interface_inst (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .req_valid_i         (fetch_req_valid),
        .req_vaddr_i         (fetch_pc),
        .redirect_i          (redirect_valid_i),
        .icache_resp_valid_i (icache_resp_valid),
        .icache_resp_line_i  (icache_resp_line),
        .tlb_xcpt_i          (tlb_xcpt),
        .icache_req_valid_o  (icache_req_valid),
        .icache_req_idx_o    (icache_idx),
        .tlb_req_valid_o     (tlb_req_valid),
        .tlb_vpn_o           (tlb_vpn),
        .fetch_valid_o       (fetch_valid),
        .fetch_pc_o          (fetch_pc_o),
        .fetch_instr_o       (fetch_instr_o),
        .fetch_cause_o       (fetch_cause)
    );

    icache_array icache_array_inst (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .fill_valid_i (fill_valid_i),
        .fill_set_i   (fill_set_i),
        .fill_line_i  (fill_line_i),
        .req_valid_i  (icache_req_valid),
        .req_idx_i    (icache_idx),
        .resp_valid_o (icache_resp_valid),
        .resp_line_o  (icache_resp_line)
    );

endmodule

`default_nettype wire

//--- sim/fetch_top_tb.sv
// Testbench for the fetch front end, redirects from a table checked against a memory and page model
`timescale 1ns/1ps
`default_nettype none

module fetch_top_tb;

    localparam int NUM_ENTRIES  = 8;
    localparam int NUM_PAGES    = 3;
    localparam int NUM_SETS     = 1 << icache_pkg::SET_BITS;
    localparam int SETUP_CYCLES = 8 + NUM_SETS + NUM_PAGES + 32;
    localparam int FETCH_WAIT   = 16;
    localparam int QUIET_CYCLES = 8;

    // One redirect, the fetches it should produce and the cause of the last one
    typedef struct packed {
        logic [fetch_pkg::ADDR_SIZE-1:0] addr;
        logic [7:0]                      count;
        fetch_pkg::fetch_cause_e         cause;
        logic                            mid_miss;
    } entry_t;

    logic                                    clk;
    logic                                    rstn;
    logic                                    redirect_valid;
    logic [fetch_pkg::ADDR_SIZE-1:0]         redirect_pc;
    logic                                    fill_valid;
    logic [icache_pkg::SET_BITS-1:0]         fill_set;
    logic [icache_pkg::LINE_SIZE-1:0]        fill_line;
    logic                                    tlb_load_valid;
    logic [$clog2(fetch_pkg::TLB_SLOTS)-1:0] tlb_load_slot;
    logic [fetch_pkg::VPN_SIZE-1:0]          tlb_load_vpn;
    logic                                    fetch_valid;
    logic [fetch_pkg::ADDR_SIZE-1:0]         fetch_pc;
    logic [fetch_pkg::INST_SIZE-1:0]         fetch_instr;
    fetch_pkg::fetch_cause_e                 fetch_cause;

    // Reference memory and page model
    logic [icache_pkg::LINE_SIZE-1:0] mirror [NUM_SETS];
    logic [fetch_pkg::VPN_SIZE-1:0]   mapped_vpn [NUM_PAGES];
    entry_t                           table_q [NUM_ENTRIES];

    integer seed;
    int     errors;
    int     checks;
    int     cycle_count;
    int     cycle_limit;
    bit     started;

    fetch_top fetch_top_inst (
        .clk_i            (clk),
        .rstn_i           (rstn),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .fill_valid_i     (fill_valid),
        .fill_set_i       (fill_set),
        .fill_line_i      (fill_line),
        .tlb_load_valid_i (tlb_load_valid),
        .tlb_load_slot_i  (tlb_load_slot),
        .tlb_load_vpn_i   (tlb_load_vpn),
        .fetch_valid_o    (fetch_valid),
        .fetch_pc_o       (fetch_pc),
        .fetch_instr_o    (fetch_instr),
        .fetch_cause_o    (fetch_cause)
    );

    always #4 clk = ~clk;

    // Instruction at an address: line from bits 11 to 4, word from bits 3 to 2
    function automatic logic [fetch_pkg::INST_SIZE-1:0] expected_instr(
        input logic [fetch_pkg::ADDR_SIZE-1:0] addr
    );
        logic [icache_pkg::LINE_SIZE-1:0] line;
        line = mirror[addr[11:4]];
        return line[addr[3:2] * fetch_pkg::INST_SIZE +: fetch_pkg::INST_SIZE];
    endfunction

    task automatic build_table();
        // Long run over three lines, ends on the last word of a line
        table_q[0] = '{40'h00_0012_3000, 8'd12, fetch_pkg::CauseNone, 1'b0};
        // Redirect into a pending miss
        table_q[1] = '{40'h00_0045_6208, 8'd6, fetch_pkg::CauseNone, 1'b1};
        table_q[2] = '{40'h00_0045_6302, 8'd1, fetch_pkg::CauseMisaligned, 1'b0};
        // Page never loaded into the TLB
        table_q[3] = '{40'h00_0077_7000, 8'd1, fetch_pkg::CauseFetchFault, 1'b0};
        // Runs off the end of a mapped page
        table_q[4] = '{40'h00_0012_3ff0, 8'd5, fetch_pkg::CauseFetchFault, 1'b0};
        table_q[5] = '{40'h00_00ab_c040, 8'd8, fetch_pkg::CauseNone, 1'b0};
        table_q[6] = '{40'h00_00ab_c7a4, 8'd4, fetch_pkg::CauseNone, 1'b1};
        table_q[7] = '{40'h00_0012_3001, 8'd1, fetch_pkg::CauseMisaligned, 1'b0};
    endtask

    // Random lines into every set, mirrored locally
    task automatic fill_cache();
        logic [icache_pkg::LINE_SIZE-1:0] line;
        for (int s = 0; s < NUM_SETS; s++) begin
            line = {$random(seed), $random(seed), $random(seed), $random(seed)};
            mirror[s] = line;
            @(posedge clk);
            #1;
            fill_valid = 1'b1;
            fill_set   = (icache_pkg::SET_BITS)'(s);
            fill_line  = line;
        end
        @(posedge clk);
        #1;
        fill_valid = 1'b0;
    endtask

    task automatic load_tlb();
        for (int p = 0; p < NUM_PAGES; p++) begin
            @(posedge clk);
            #1;
            tlb_load_valid = 1'b1;
            tlb_load_slot  = ($clog2(fetch_pkg::TLB_SLOTS))'(p);
            tlb_load_vpn   = mapped_vpn[p];
        end
        @(posedge clk);
        #1;
        tlb_load_valid = 1'b0;
    endtask

    // One-cycle redirect strobe
    task automatic redirect_to(input logic [fetch_pkg::ADDR_SIZE-1:0] addr);
        @(posedge clk);
        #1;
        redirect_valid = 1'b1;
        redirect_pc    = addr;
        started        = 1'b1;
        @(posedge clk);
        #1;
        redirect_valid = 1'b0;
    endtask

    // Hold off until the cache request of a miss has gone out
    task automatic wait_for_miss();
        int waited;
        bit seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < FETCH_WAIT) begin
            @(negedge clk);
            waited++;
            if (fetch_valid) begin
                $display("FAILED at %0t: delivery of pc %h while a miss was expected",
                         $time, fetch_pc);
                errors++;
            end
            seen = fetch_top_inst.icache_req_valid;
        end
        if (!seen) begin
            $display("No cache request went out within %0d cycles before the redirect",
                     FETCH_WAIT);
            errors++;
        end
    endtask

    task automatic expect_fetch(input logic [fetch_pkg::ADDR_SIZE-1:0] pc,
                                input fetch_pkg::fetch_cause_e cause);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!fetch_valid && waited < FETCH_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!fetch_valid) begin
            $display("No fetch was delivered within %0d cycles while waiting for pc %h",
                     FETCH_WAIT, pc);
            errors++;
        end else begin
            checks++;
            if (fetch_pc !== pc) begin
                $display("FAILED at %0t: pc %h, expected %h", $time, fetch_pc, pc);
                errors++;
            end
            if (fetch_cause !== cause) begin
                $display("FAILED at %0t: pc %h cause %0d, expected %0d",
                         $time, pc, fetch_cause, cause);
                errors++;
            end
            // Instruction only matters on a normal delivery
            if (cause == fetch_pkg::CauseNone && fetch_instr !== expected_instr(pc)) begin
                $display("FAILED at %0t: pc %h instr %h, expected %h",
                         $time, pc, fetch_instr, expected_instr(pc));
                errors++;
            end
        end
    endtask

    // Fetch is halted, nothing may come out
    task automatic quiet_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            if (fetch_valid) begin
                $display("FAILED at %0t: delivery of pc %h after an exception",
                         $time, fetch_pc);
                errors++;
            end
        end
    endtask

    // No delivery before the first redirect
    always @(negedge clk) begin
        if (rstn && !started && fetch_valid) begin
            $display("FAILED at %0t: delivery before the first redirect", $time);
            errors++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("Fetches checked: %0d, errors: %0d", checks, errors);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        fetch_pkg::fetch_cause_e cause;
        clk            = 1'b0;
        rstn           = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        fill_valid     = 1'b0;
        fill_set       = '0;
        fill_line      = '0;
        tlb_load_valid = 1'b0;
        tlb_load_slot  = '0;
        tlb_load_vpn   = '0;
        seed           = 32'hbecee61a;
        errors         = 0;
        checks         = 0;
        cycle_count    = 0;
        started        = 1'b0;
        mapped_vpn[0]  = 28'h000_0123;
        mapped_vpn[1]  = 28'h000_0456;
        mapped_vpn[2]  = 28'h000_0abc;
        build_table();
        // Budget grows with the fetch count of every entry
        cycle_limit = SETUP_CYCLES;
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            cycle_limit += (int'(table_q[e].count) + 4) * 4;
        end
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;
        fill_cache();
        load_tlb();
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            if (table_q[e].mid_miss) begin
                wait_for_miss();
            end
            redirect_to(table_q[e].addr);
            for (int k = 0; k < int'(table_q[e].count); k++) begin
                cause = (k == int'(table_q[e].count) - 1) ? table_q[e].cause
                                                          : fetch_pkg::CauseNone;
                expect_fetch(table_q[e].addr + (fetch_pkg::ADDR_SIZE)'(4 * k), cause);
            end
            if (table_q[e].cause != fetch_pkg::CauseNone) begin
                quiet_cycles(QUIET_CYCLES);
            end
        end
        $display("Fetches checked: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- fetch_top.f
hw/fetch_pkg.sv
hw/icache_pkg.sv
hw/pc_gen.sv
hw/itlb.sv
hw/icache_array.sv
hw/icache_interface.sv
hw/fetch_top.sv
sim/fetch_top_tb.sv
